/* verilog.f */
source/step_motor_pkg.sv
source/speed_table.sv
source/ramp_scheduler.sv
source/single_step_motor.sv
source/step_motor.sv
testbench/step_motor_properties.sv
testbench/tb_step_motor.sv

/* Bender.yml */
package:
  name: step_motor

sources:
  - files:
      - source/step_motor_pkg.sv
      - source/speed_table.sv
      - source/ramp_scheduler.sv
      - source/single_step_motor.sv
      - source/step_motor.sv
  - target: test
    files:
      - testbench/step_motor_properties.sv
      - testbench/tb_step_motor.sv

/* testbench/tb_step_motor.sv */
`timescale 1ns/1ns

module tb_step_motor;
	import step_motor_pkg::*;

	localparam int DRV_DLY = 2;
	localparam int TBL_LEN = 8;
	localparam int ADDR_LAST = TBL_LEN - 1;
	localparam int NUM_ROWS = 8;
	localparam int START_TIMEOUT = 4;	// clocks
	localparam int MOVE_TIMEOUT = 20000;

	typedef struct packed {
		int ch;
		int steps;
		int speed;
		int stroke;
		bit dir;
		int ms;
		int zpd_at;	// pulse count that raises the zero sensor, -1 none
		int stop_at;	// pulse count that sends a stop, -1 none
		int exp_pulses;
		bit exp_tp;
		bit pair;	// starts together with the next row
	} row_t;

	logic clk;
	logic resetn;
	logic i_tbl_init;
	logic i_tbl_wr_en;
	logic [SPEED_W-1:0] i_tbl_data;
	motor_cmd_t [MOTOR_NBR-1:0] i_cmd;
	logic [MOTOR_NBR-1:0] i_start;
	logic [MOTOR_NBR-1:0] i_stop;
	logic [MOTOR_NBR-1:0] i_zpd;
	motor_pins_t [MOTOR_NBR-1:0] o_pins;
	motor_status_t [MOTOR_NBR-1:0] o_status;

	int cyc;	// after edge n the ring sits on bit n mod DIV_NBR
	int ramp [TBL_LEN];
	row_t rows [NUM_ROWS];

	step_motor step_motor_inst (
		.clk(clk),
		.resetn(resetn),
		.i_tbl_init(i_tbl_init),
		.i_tbl_wr_en(i_tbl_wr_en),
		.i_tbl_data(i_tbl_data),
		.i_cmd(i_cmd),
		.i_start(i_start),
		.i_stop(i_stop),
		.i_zpd(i_zpd),
		.o_pins(o_pins),
		.o_status(o_status)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!resetn) begin
			cyc <= 0;
		end
		else begin
			cyc <= cyc + 1;
		end
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_pins(input int ch, input motor_pins_t got, input motor_pins_t exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH o_pins[%0d] got %h expected %h", ch, got, exp));
		end
	endtask

	task automatic check_status(input int ch, input motor_status_t got, input motor_status_t exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH o_status[%0d] got %h expected %h", ch, got, exp));
		end
	endtask

	task automatic check_gap(input int ch, input string what, input int got, input int exp);
		if (got != exp) begin
			stop_with_failure($sformatf("MISMATCH o_pins[%0d].drive %s got %h expected %h",
				ch, what, got, exp));
		end
	endtask

	task automatic check_count(input int ch, input int got, input int exp);
		if (got != exp) begin
			stop_with_failure($sformatf("MISMATCH o_pins[%0d].drive pulse count got %h expected %h",
				ch, got, exp));
		end
	endtask

	// delay in ticks of step k in a move of n steps
	function automatic int step_delay(input int n, input int k, input int speed);
		int a;
		int d;
		int w;
		a = (k < ADDR_LAST) ? k : ADDR_LAST;
		d = (n - 1 - k < ADDR_LAST) ? n - 1 - k : ADDR_LAST;
		w = ramp[a];
		if (ramp[d] > w) begin
			w = ramp[d];
		end
		if (speed > w) begin
			w = speed;
		end
		return w;
	endfunction

	task automatic load_table();
		@(posedge clk);
		#DRV_DLY;
		i_tbl_init = 1'b1;
		for (int t = 0; t < TBL_LEN; t++) begin
			@(posedge clk);
			#DRV_DLY;
			i_tbl_wr_en = 1'b1;
			i_tbl_data = SPEED_W'(ramp[t]);
		end
		@(posedge clk);
		#DRV_DLY;
		i_tbl_wr_en = 1'b0;
		i_tbl_init = 1'b0;
	endtask

	task automatic start_move(input row_t r);
		i_cmd[r.ch] = '{steps: STEP_W'(r.steps), speed: SPEED_W'(r.speed),
			stroke: STEP_W'(r.stroke), dir: r.dir, ms: MS_W'(r.ms)};
		i_start[r.ch] = 1'b1;
	endtask

	task automatic run_row(input row_t r);
		int pulses;
		int last;
		int waited;
		bit stopped;
		motor_pins_t on_pins;
		motor_status_t end_status;
		pulses = 0;
		last = 0;
		waited = 0;
		stopped = 1'b0;
		on_pins = '{drive: 1'b1, dir: r.dir, ms: MS_W'(r.ms)};
		while (!o_status[r.ch].busy) begin
			if (waited == START_TIMEOUT) begin
				stop_with_failure($sformatf("channel %0d did not go busy after start", r.ch));
			end
			@(negedge clk);
			waited++;
		end
		check_pins(r.ch, o_pins[r.ch], '{drive: 1'b0, dir: r.dir, ms: MS_W'(r.ms)});
		waited = 0;
		while (o_status[r.ch].busy) begin
			if (waited == MOVE_TIMEOUT) begin
				stop_with_failure($sformatf("channel %0d still busy after %0d clocks",
					r.ch, MOVE_TIMEOUT));
			end
			@(posedge clk);
			#DRV_DLY;
			i_stop[r.ch] = 1'b0;
			if (pulses == r.stop_at && !stopped) begin
				i_stop[r.ch] = 1'b1;
				stopped = 1'b1;
			end
			if (pulses == r.zpd_at) begin
				i_zpd[r.ch] = 1'b1;
			end
			@(negedge clk);
			waited++;
			if (o_pins[r.ch].drive) begin
				if (cyc % DIV_NBR != r.ch) begin
					stop_with_failure($sformatf("channel %0d stepped outside its slot", r.ch));
				end
				if (pulses >= r.steps) begin
					stop_with_failure($sformatf("channel %0d gave more pulses than steps", r.ch));
				end
				check_pins(r.ch, o_pins[r.ch], on_pins);
				if (pulses > 0) begin
					check_gap(r.ch, $sformatf("gap before pulse %0d", pulses), cyc - last,
						step_delay(r.steps, pulses, r.speed) * DIV_NBR);
				end
				last = cyc;
				pulses++;
			end
		end
		check_count(r.ch, pulses, r.exp_pulses);
		if (r.exp_pulses == r.steps || r.stop_at >= 0 || r.zpd_at >= 0) begin
			// busy dropped on the edge before this sample
			check_gap(r.ch, "clocks to busy fall", cyc - 1 - last, DIV_NBR);
		end
		end_status = '{busy: 1'b0, zpsign: ZPD_MASK[r.ch] & i_zpd[r.ch], tpsign: r.exp_tp};
		check_status(r.ch, o_status[r.ch], end_status);
		@(posedge clk);
		#DRV_DLY;
		i_stop[r.ch] = 1'b0;
		i_zpd[r.ch] = 1'b0;
	endtask

	initial begin
		int i;
		int assert_fails;
		resetn = 1'b0;
		i_tbl_init = 1'b0;
		i_tbl_wr_en = 1'b0;
		i_tbl_data = '0;
		i_cmd = '0;
		i_start = '0;
		i_stop = '0;
		i_zpd = '0;
		for (int t = 0; t < TBL_LEN; t++) begin
			ramp[t] = 40 - 4 * t;	// 40 down to 12
		end
		// ch steps speed stroke dir ms zpd_at stop_at pulses tp pair
		rows[0] = '{0, 5, 10, 1000, 1'b1, 3, -1, -1, 5, 1'b0, 1'b0};
		rows[1] = '{2, 20, 14, 1000, 1'b1, 5, -1, -1, 20, 1'b0, 1'b0};
		rows[2] = '{3, 10, 12, 6, 1'b1, 1, -1, -1, 6, 1'b1, 1'b0};
		rows[3] = '{0, 30, 12, 1000, 1'b0, 2, 4, -1, 4, 1'b0, 1'b0};
		rows[4] = '{1, 30, 12, 1000, 1'b0, 2, 4, -1, 30, 1'b0, 1'b0};
		rows[5] = '{2, 20, 12, 1000, 1'b1, 4, -1, 3, 3, 1'b0, 1'b0};
		rows[6] = '{0, 6, 20, 6, 1'b1, 2, -1, -1, 6, 1'b1, 1'b1};
		rows[7] = '{3, 4, 12, 6, 1'b0, 7, -1, -1, 4, 1'b0, 1'b0};

		repeat (4) @(posedge clk);
		#DRV_DLY;
		resetn = 1'b1;
		@(negedge clk);
		for (int m = 0; m < MOTOR_NBR; m++) begin
			check_status(m, o_status[m], '{busy: 1'b0, zpsign: 1'b0, tpsign: 1'b1});
			check_pins(m, o_pins[m], '0);
		end
		load_table();

		i = 0;
		while (i < NUM_ROWS) begin
			@(posedge clk);
			#DRV_DLY;
			start_move(rows[i]);
			if (rows[i].pair) begin
				start_move(rows[i + 1]);
			end
			@(posedge clk);
			#DRV_DLY;
			i_start = '0;
			if (rows[i].pair) begin
				fork
					run_row(rows[i]);
					run_row(rows[i + 1]);
				join
				i += 2;
			end
			else begin
				run_row(rows[i]);
				i++;
			end
		end

		repeat (2) @(posedge clk);
		assert_fails = step_motor_inst.gen_motor[0].single_step_motor_inst.props_inst.fail_cnt
			+ step_motor_inst.gen_motor[1].single_step_motor_inst.props_inst.fail_cnt
			+ step_motor_inst.gen_motor[2].single_step_motor_inst.props_inst.fail_cnt
			+ step_motor_inst.gen_motor[3].single_step_motor_inst.props_inst.fail_cnt;
		if (assert_fails == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else begin
			stop_with_failure($sformatf("%0d concurrent assertions failed", assert_fails));
		end
	end

endmodule

/* testbench/step_motor_properties.sv */
`timescale 1ns/1ns

module step_motor_properties (
	input  logic clk,
	input  logic resetn,
	input  logic i_tick,
	input  step_motor_pkg::motor_pins_t i_pins,
	input  step_motor_pkg::motor_status_t i_status
);
	import step_motor_pkg::*;

	int fail_cnt = 0;

	// the other slots of the ring stay quiet
	a_drive_on_tick: assert property (@(posedge clk) disable iff (!resetn)
		i_tick |=> !i_pins.drive [*DIV_NBR-1])
	else begin
		fail_cnt++;
		$error("drive high outside the channel tick");
	end

	a_drive_one_clock: assert property (@(posedge clk) disable iff (!resetn)
		i_pins.drive |=> !i_pins.drive)
	else begin
		fail_cnt++;
		$error("drive high for two clocks");
	end

	// sync reset clears the FSM one edge later
	a_idle_after_reset: assert property (@(posedge clk) !resetn |=> !i_status.busy)
	else begin
		fail_cnt++;
		$error("busy set after reset");
	end

	a_no_pulse_idle: assert property (@(posedge clk) disable iff (!resetn)
		!i_status.busy |=> !i_pins.drive)
	else begin
		fail_cnt++;
		$error("step pulse while idle");
	end

endmodule

bind single_step_motor step_motor_properties props_inst (
	.clk(clk),
	.resetn(resetn),
	.i_tick(i_tick),
	.i_pins(o_pins),
	.i_status(o_status)
);

/* source/step_motor.sv */
`timescale 1ns/1ns

module step_motor (
	input  logic clk,
	input  logic resetn,

	input  logic i_tbl_init,
	input  logic i_tbl_wr_en,
	input  logic [step_motor_pkg::SPEED_W-1:0] i_tbl_data,

	input  step_motor_pkg::motor_cmd_t [step_motor_pkg::MOTOR_NBR-1:0] i_cmd,
	input  logic [step_motor_pkg::MOTOR_NBR-1:0] i_start,
	input  logic [step_motor_pkg::MOTOR_NBR-1:0] i_stop,
	input  logic [step_motor_pkg::MOTOR_NBR-1:0] i_zpd,	// zero sensors

	output step_motor_pkg::motor_pins_t [step_motor_pkg::MOTOR_NBR-1:0] o_pins,
	output step_motor_pkg::motor_status_t [step_motor_pkg::MOTOR_NBR-1:0] o_status
);
	import step_motor_pkg::*;

	logic [MOTOR_NBR-1:0] tick;
	logic [MOTOR_NBR-1:0][ADDR_W-1:0] ch_acce_addr;
	logic [MOTOR_NBR-1:0][ADDR_W-1:0] ch_deac_addr;
	logic [ADDR_W-1:0] tbl_acce_addr;
	logic [ADDR_W-1:0] tbl_deac_addr;
	logic [ADDR_W-1:0] addr_max;
	logic [SPEED_W-1:0] acce_data;
	logic [SPEED_W-1:0] deac_data;

	speed_table speed_table_inst (
		.clk(clk),
		.resetn(resetn),
		.i_init(i_tbl_init),
		.i_wr_en(i_tbl_wr_en),
		.i_data(i_tbl_data),
		.i_addr_a(tbl_acce_addr),
		.i_addr_b(tbl_deac_addr),
		.o_data_a(acce_data),
		.o_data_b(deac_data),
		.o_addr_max(addr_max)
	);

	ramp_scheduler ramp_scheduler_inst (
		.clk(clk),
		.resetn(resetn),
		.i_acce_addr(ch_acce_addr),
		.i_deac_addr(ch_deac_addr),
		.o_tick(tick),
		.o_acce_addr(tbl_acce_addr),
		.o_deac_addr(tbl_deac_addr)
	);

	for (genvar m = 0; m < MOTOR_NBR; m++) begin : gen_motor
		single_step_motor #(
			.ZPD_EN(ZPD_MASK[m])
		) single_step_motor_inst (
			.clk(clk),
			.resetn(resetn),
			.i_tick(tick[m]),
			.i_addr_max(addr_max),
			.i_acce_data(acce_data),	// shared, valid in own slot only
			.i_deac_data(deac_data),
			.i_cmd(i_cmd[m]),
			.i_start(i_start[m]),
			.i_stop(i_stop[m]),
			.i_zpd(i_zpd[m]),
			.o_acce_addr(ch_acce_addr[m]),
			.o_deac_addr(ch_deac_addr[m]),
			.o_pins(o_pins[m]),
			.o_status(o_status[m])
		);
	end

endmodule

/* source/single_step_motor.sv */
`timescale 1ns/1ns

module single_step_motor #(
	parameter bit ZPD_EN = 1'b1
) (
	input  logic clk,
	input  logic resetn,
	input  logic i_tick,

	input  logic [step_motor_pkg::ADDR_W-1:0] i_addr_max,
	input  logic [step_motor_pkg::SPEED_W-1:0] i_acce_data,
	input  logic [step_motor_pkg::SPEED_W-1:0] i_deac_data,

	input  step_motor_pkg::motor_cmd_t i_cmd,
	input  logic i_start,
	input  logic i_stop,
	input  logic i_zpd,

	output logic [step_motor_pkg::ADDR_W-1:0] o_acce_addr,
	output logic [step_motor_pkg::ADDR_W-1:0] o_deac_addr,
	output step_motor_pkg::motor_pins_t o_pins,
	output step_motor_pkg::motor_status_t o_status
);
	import step_motor_pkg::*;

	motor_state_e state;
	motor_cmd_t cmd_r;
	logic signed [STEP_W-1:0] pos;
	logic [STEP_W-1:0] rem;	// steps still to issue
	logic [STEP_W-1:0] fidx;	// step index of next table fetch
	logic [STEP_W-1:0] didx;
	logic [STEP_W-1:0] max_ext;
	logic [SPEED_W-1:0] cnt;
	logic [SPEED_W-1:0] ramp_max;
	logic [SPEED_W-1:0] delay;
	logic [1:0] tick_d;
	logic pend;
	logic stop_req;
	logic stop_hit;
	logic zero_hit;
	logic term_hit;
	logic addr_en;
	logic drive;

	assign max_ext = {{(STEP_W-ADDR_W){1'b0}}, i_addr_max};
	assign didx = cmd_r.steps - fidx - 1'b1;	// steps left after this one

	// addresses go out on the tick, data is back two clocks later
	assign addr_en = i_tick && ((state == FETCH && !pend) || state == PULSE);

	always_comb begin
		o_acce_addr = '0;
		o_deac_addr = '0;
		if (addr_en) begin
			o_acce_addr = (fidx < max_ext) ? fidx[ADDR_W-1:0] : i_addr_max;
			o_deac_addr = (didx < max_ext) ? didx[ADDR_W-1:0] : i_addr_max;
		end
	end

	// slowest of accel, decel and cruise wins
	assign ramp_max = (i_acce_data > i_deac_data) ? i_acce_data : i_deac_data;
	assign delay = (ramp_max > cmd_r.speed) ? ramp_max : cmd_r.speed;

	assign stop_hit = stop_req | i_stop;
	assign zero_hit = ZPD_EN && !cmd_r.dir && i_zpd;
	assign term_hit = cmd_r.dir && (pos >= $signed(cmd_r.stroke));

	assign drive = (state == PULSE) && i_tick
		&& !(stop_hit || zero_hit || term_hit || rem == '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
			cmd_r <= '0;
			pos <= '0;
			rem <= '0;
			fidx <= '0;
			cnt <= '0;
			tick_d <= '0;
			pend <= 1'b0;
			stop_req <= 1'b0;
		end
		else begin
			tick_d <= {tick_d[0], i_tick};
			if (i_stop && state != IDLE) begin
				stop_req <= 1'b1;
			end

			case (state)
				IDLE: begin
					if (i_start) begin
						cmd_r <= i_cmd;
						rem <= i_cmd.steps;
						fidx <= '0;
						pend <= 1'b0;
						stop_req <= 1'b0;
						state <= FETCH;
					end
				end
				FETCH: begin
					if (i_tick && !pend) begin
						pend <= 1'b1;
					end
					else if (tick_d[1] && pend) begin	// table words valid now
						pend <= 1'b0;
						fidx <= fidx + 1'b1;
						if (delay > 1 && rem != '0) begin
							cnt <= delay - 1'b1;
							state <= WAIT;
						end
						else begin
							state <= PULSE;
						end
					end
				end
				WAIT: begin
					if (i_tick) begin
						cnt <= cnt - 1'b1;
						if (cnt == 1) begin
							state <= PULSE;
						end
					end
				end
				PULSE: begin
					if (i_tick) begin
						if (drive) begin
							pos <= cmd_r.dir ? pos + 1'b1 : pos - 1'b1;
							rem <= rem - 1'b1;
							pend <= 1'b1;	// next step's read issued with this pulse
							state <= FETCH;
						end
						else begin
							state <= IDLE;	// done, or a limit was reached
						end
					end
				end
				default: state <= IDLE;
			endcase

			// abort wins over anything above
			if (state != IDLE && i_tick && (stop_hit || zero_hit)) begin
				state <= IDLE;
				if (zero_hit) begin
					pos <= '0;	// homed
				end
			end
		end
	end

	assign o_pins = '{drive: drive, dir: cmd_r.dir, ms: cmd_r.ms};
	assign o_status = '{
		busy: (state != IDLE),
		zpsign: ZPD_EN && i_zpd,
		tpsign: (pos == $signed(cmd_r.stroke))
	};

endmodule

/* source/ramp_scheduler.sv */
`timescale 1ns/1ns

module ramp_scheduler (
	input  logic clk,
	input  logic resetn,

	input  logic [step_motor_pkg::MOTOR_NBR-1:0][step_motor_pkg::ADDR_W-1:0] i_acce_addr,
	input  logic [step_motor_pkg::MOTOR_NBR-1:0][step_motor_pkg::ADDR_W-1:0] i_deac_addr,

	output logic [step_motor_pkg::MOTOR_NBR-1:0] o_tick,
	output logic [step_motor_pkg::ADDR_W-1:0] o_acce_addr,
	output logic [step_motor_pkg::ADDR_W-1:0] o_deac_addr
);
	import step_motor_pkg::*;

	logic [DIV_NBR-1:0] ring;
	logic [ADDR_W-1:0] acce_or;
	logic [ADDR_W-1:0] deac_or;

	// one-hot clock enable ring
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ring <= DIV_NBR'(1);
		end
		else begin
			ring <= {ring[DIV_NBR-2:0], ring[DIV_NBR-1]};
		end
	end

	assign o_tick = ring[MOTOR_NBR-1:0];	// unused ring bits are idle slots

	// only the channel owning the slot gets through
	always_comb begin
		acce_or = '0;
		deac_or = '0;
		for (int m = 0; m < MOTOR_NBR; m++) begin
			acce_or |= i_acce_addr[m] & {ADDR_W{ring[m]}};
			deac_or |= i_deac_addr[m] & {ADDR_W{ring[m]}};
		end
	end

	always_ff @(posedge clk) begin
		o_acce_addr <= acce_or;
		o_deac_addr <= deac_or;
	end

endmodule

/* source/speed_table.sv */
`timescale 1ns/1ns

module speed_table (
	input  logic clk,
	input  logic resetn,

	input  logic i_init,
	input  logic i_wr_en,
	input  logic [step_motor_pkg::SPEED_W-1:0] i_data,

	input  logic [step_motor_pkg::ADDR_W-1:0] i_addr_a,
	input  logic [step_motor_pkg::ADDR_W-1:0] i_addr_b,
	output logic [step_motor_pkg::SPEED_W-1:0] o_data_a,
	output logic [step_motor_pkg::SPEED_W-1:0] o_data_b,
	output logic [step_motor_pkg::ADDR_W-1:0] o_addr_max
);
	import step_motor_pkg::*;

	logic [SPEED_W-1:0] mem [2**ADDR_W];
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] addr_a;
	logic we;

	assign we = i_init & i_wr_en;
	assign addr_a = we ? wr_addr : i_addr_a;	// loader owns port A while writing

	// write pointer restarts whenever init drops
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_addr <= '0;
			o_addr_max <= '0;
		end
		else if (!i_init) begin
			wr_addr <= '0;
		end
		else if (i_wr_en) begin
			wr_addr <= wr_addr + 1'b1;
			o_addr_max <= wr_addr;	// index of last entry written
		end
	end

	// port A, read before write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr_a] <= i_data;
		end
		o_data_a <= mem[addr_a];
	end

	// port B, read only
	always_ff @(posedge clk) begin
		o_data_b <= mem[i_addr_b];
	end

endmodule

/* source/step_motor_pkg.sv */
package step_motor_pkg;

	localparam int MOTOR_NBR = 4;
	// ring length, also clocks per channel tick
	// table read takes 2 clocks so this must stay >= 3 and >= MOTOR_NBR
	localparam int DIV_NBR = 4;

	localparam int STEP_W = 16;	// step counts, position, stroke
	localparam int SPEED_W = 16;	// delays in ticks
	localparam int ADDR_W = 6;	// 64 ramp entries
	localparam int MS_W = 3;

	localparam logic [MOTOR_NBR-1:0] ZPD_MASK = 4'b0101;	// zero detection per channel

	typedef struct packed {
		logic [STEP_W-1:0] steps;
		logic [SPEED_W-1:0] speed;	// cruise delay
		logic [STEP_W-1:0] stroke;	// terminal position
		logic dir;	// 1 = positive
		logic [MS_W-1:0] ms;
	} motor_cmd_t;

	typedef struct packed {
		logic drive;
		logic dir;
		logic [MS_W-1:0] ms;
	} motor_pins_t;

	typedef struct packed {
		logic busy;
		logic zpsign;
		logic tpsign;
	} motor_status_t;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,	// table read in flight
		WAIT,	// counting delay ticks
		PULSE	// step goes out on next tick
	} motor_state_e;

endpackage
